// File: rtl/dft4_pkg.sv
// word layout is {sign, exponent, mantissa} with no hidden bit; acc_w holds a 4-term sum only
`default_nettype none

package dft4_pkg;

  localparam int exp_w    = 4;
  localparam int man_w    = 4;
  localparam int word_w   = 1 + exp_w + man_w;
  localparam int n_points = 4;

  // field positions inside one word
  localparam int man_lsb  = 0;
  localparam int exp_lsb  = man_lsb + man_w;
  localparam int sign_pos = exp_lsb + exp_w;

  // which input bus a lane treats as its own
  typedef enum logic {
    lane_real,
    lane_imag
  } lane_e;

  // even: pair sums, odd: pair differences
  typedef enum logic {
    pattern_even,
    pattern_odd
  } pattern_e;

  // mantissa, guard bits, two growth bits for four terms, sign
  function automatic int acc_w(input int low_ext);
    return man_w + low_ext + 3;
  endfunction

endpackage

`default_nettype wire

// File: rtl/group_aligner.sv
// aligns four words to their largest exponent; shifted-out bits are truncated, two cycle latency
`timescale 1ns/1ps
`default_nettype none

module group_aligner
  import dft4_pkg::*;
#(
  parameter int low_expand = 2
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [n_points*word_w-1:0]          words,
  output logic [exp_w-1:0]                    max_exp,
  output logic signed [acc_w(low_expand)-1:0] term0,
  output logic signed [acc_w(low_expand)-1:0] term1,
  output logic signed [acc_w(low_expand)-1:0] term2,
  output logic signed [acc_w(low_expand)-1:0] term3
);

  localparam int aw = acc_w(low_expand);

  logic [exp_w-1:0] exps [n_points];
  logic [exp_w-1:0] grp_max;

  logic [exp_w-1:0] max_q;
  logic             sign_q [n_points];
  logic [man_w-1:0] man_q  [n_points];
  logic [exp_w-1:0] dist_q [n_points];  // right shift per term

  logic [aw-1:0]        shifted [n_points];
  logic signed [aw-1:0] term_q  [n_points];
  logic [exp_w-1:0]     max_q2;

  always_comb begin
    grp_max = '0;
    for (int k = 0; k < n_points; k++) begin
      exps[k] = words[k*word_w+exp_lsb +: exp_w];
      if (exps[k] > grp_max) begin
        grp_max = exps[k];
      end
    end
  end

  // stage 1: group max plus raw fields
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      max_q <= '0;
      for (int k = 0; k < n_points; k++) begin
        sign_q[k] <= 1'b0;
        man_q[k]  <= '0;
        dist_q[k] <= '0;
      end
    end else begin
      max_q <= grp_max;
      for (int k = 0; k < n_points; k++) begin
        sign_q[k] <= words[k*word_w+sign_pos];
        man_q[k]  <= words[k*word_w+man_lsb +: man_w];
        dist_q[k] <= grp_max - exps[k];
      end
    end
  end

  always_comb begin
    for (int k = 0; k < n_points; k++) begin
      shifted[k] = ({{(aw-man_w){1'b0}}, man_q[k]} << low_expand) >> dist_q[k];
    end
  end

  // stage 2: signed aligned terms, max follows along
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      max_q2 <= '0;
      for (int k = 0; k < n_points; k++) begin
        term_q[k] <= '0;
      end
    end else begin
      max_q2 <= max_q;
      for (int k = 0; k < n_points; k++) begin
        term_q[k] <= sign_q[k] ? -$signed(shifted[k]) : $signed(shifted[k]);
      end
    end
  end

  assign max_exp = max_q2;
  assign term0   = term_q[0];
  assign term1   = term_q[1];
  assign term2   = term_q[2];
  assign term3   = term_q[3];

  // a term never shifts further than the group max allows
  for (genvar g = 0; g < n_points; g++) begin : g_dist_chk
    a_dist_range : assert property (
      @(posedge clk) disable iff (!rst) dist_q[g] <= max_q
    );
  end

endmodule

`default_nettype wire

// File: rtl/bfp_lane.sv
// one output component (real or imag) of the 4-point DFT; sums registered two edges after sampling
`timescale 1ns/1ps
`default_nettype none

module bfp_lane
  import dft4_pkg::*;
#(
  parameter int    low_expand = 2,
  parameter lane_e lane       = lane_real
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [n_points*word_w-1:0]          x_real,
  input  logic [n_points*word_w-1:0]          x_imag,
  output logic signed [acc_w(low_expand)-1:0] sum_a0,
  output logic signed [acc_w(low_expand)-1:0] sum_a1,
  output logic signed [acc_w(low_expand)-1:0] sum_b0,
  output logic signed [acc_w(low_expand)-1:0] sum_b1,
  output logic [exp_w-1:0]                    max_exp_a,
  output logic [exp_w-1:0]                    max_exp_b
);

  localparam int aw = acc_w(low_expand);
  localparam int sw = aw + 2;  // headroom for the overflow check

  logic [n_points*word_w-1:0] own_w;
  logic [n_points*word_w-1:0] other_w;
  logic [n_points*word_w-1:0] words_a;
  logic [n_points*word_w-1:0] words_b;

  logic signed [aw-1:0] ta [n_points];
  logic signed [aw-1:0] tb [n_points];
  logic [exp_w-1:0]     max_a;
  logic [exp_w-1:0]     max_b;

  logic signed [sw-1:0] wide_a0, wide_a1, wide_b0, wide_b1;

  function automatic logic [word_w-1:0] pick(input logic [n_points*word_w-1:0] bus,
                                             input int k);
    return bus[k*word_w +: word_w];
  endfunction

  function automatic logic signed [sw-1:0] bfly(input pattern_e pat, input logic second,
                                                input logic signed [aw-1:0] t0,
                                                input logic signed [aw-1:0] t1,
                                                input logic signed [aw-1:0] t2,
                                                input logic signed [aw-1:0] t3);
    logic signed [sw-1:0] p0;
    logic signed [sw-1:0] p1;
    if (pat == pattern_even) begin
      p0 = t0 + t1;
      p1 = t2 + t3;
    end else begin
      p0 = t0 - t1;
      p1 = t2 - t3;
    end
    return second ? p0 - p1 : p0 + p1;
  endfunction

  function automatic logic fits(input logic signed [sw-1:0] v);
    return (v >= -(2 ** (aw - 1))) && (v < 2 ** (aw - 1));
  endfunction

  assign own_w   = (lane == lane_real) ? x_real : x_imag;
  assign other_w = (lane == lane_real) ? x_imag : x_real;

  // terms 0..3 sit LSB first
  assign words_a = {pick(own_w, 3), pick(own_w, 1), pick(own_w, 2), pick(own_w, 0)};
  // imag lane swaps r1/r3 to flip the sign of the cross terms
  assign words_b = (lane == lane_real) ?
                   {pick(other_w, 3), pick(other_w, 1), pick(own_w, 2), pick(own_w, 0)} :
                   {pick(other_w, 1), pick(other_w, 3), pick(own_w, 2), pick(own_w, 0)};

  group_aligner #(
    .low_expand(low_expand)
  ) u_group_a (
    .clk    (clk),
    .rst    (rst),
    .words  (words_a),
    .max_exp(max_a),
    .term0  (ta[0]),
    .term1  (ta[1]),
    .term2  (ta[2]),
    .term3  (ta[3])
  );

  group_aligner #(
    .low_expand(low_expand)
  ) u_group_b (
    .clk    (clk),
    .rst    (rst),
    .words  (words_b),
    .max_exp(max_b),
    .term0  (tb[0]),
    .term1  (tb[1]),
    .term2  (tb[2]),
    .term3  (tb[3])
  );

  assign wide_a0 = bfly(pattern_even, 1'b0, ta[0], ta[1], ta[2], ta[3]);
  assign wide_a1 = bfly(pattern_even, 1'b1, ta[0], ta[1], ta[2], ta[3]);
  assign wide_b0 = bfly(pattern_odd, 1'b0, tb[0], tb[1], tb[2], tb[3]);
  assign wide_b1 = bfly(pattern_odd, 1'b1, tb[0], tb[1], tb[2], tb[3]);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      sum_a0    <= '0;
      sum_a1    <= '0;
      sum_b0    <= '0;
      sum_b1    <= '0;
      max_exp_a <= '0;
      max_exp_b <= '0;
    end else begin
      sum_a0    <= wide_a0[aw-1:0];
      sum_a1    <= wide_a1[aw-1:0];
      sum_b0    <= wide_b0[aw-1:0];
      sum_b1    <= wide_b1[aw-1:0];
      max_exp_a <= max_a;  // keep exponent beside its sums
      max_exp_b <= max_b;
    end
  end

  // aligned terms are bounded by the aligner, so four of them fit acc_w
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst)
      fits(wide_a0) && fits(wide_a1) && fits(wide_b0) && fits(wide_b1)
  );

endmodule

`default_nettype wire

// File: rtl/sfp_packer.sv
// renormalizes lane sums to 9-bit words; exponent overflow saturates, outputs hold between dones
`timescale 1ns/1ps
`default_nettype none

module sfp_packer
  import dft4_pkg::*;
#(
  parameter int low_expand = 2
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    start,
  input  logic [n_points*acc_w(low_expand)-1:0]   real_sums,
  input  logic [n_points*acc_w(low_expand)-1:0]   imag_sums,
  input  logic [(n_points/2)*exp_w-1:0]           real_exps,
  input  logic [(n_points/2)*exp_w-1:0]           imag_exps,
  output logic [n_points*word_w-1:0]              y_real,
  output logic [n_points*word_w-1:0]              y_imag,
  output logic                                    done
);

  localparam int aw      = acc_w(low_expand);
  localparam int man_max = 2 ** man_w - 1;
  localparam int exp_max = 2 ** exp_w - 1;

  logic [2:0]                 start_d;  // matches the lane latency
  logic [n_points*word_w-1:0] real_words;
  logic [n_points*word_w-1:0] imag_words;

  function automatic logic [word_w-1:0] pack(input logic signed [aw-1:0] sum,
                                             input logic [exp_w-1:0] grp_exp);
    logic [aw-1:0]     mag;
    int                e;
    logic [word_w-1:0] w;
    mag = sum[aw-1] ? aw'(-sum) : aw'(sum);
    e   = int'(grp_exp) - low_expand;
    for (int i = 0; i < aw; i++) begin
      if (mag > man_max) begin
        mag = mag >> 1;
        e   = e + 1;
      end
    end
    if (e < 0) begin
      mag = mag >> (-e);  // below the smallest exponent
      e   = 0;
    end
    if (e > exp_max) begin
      w = {sum[aw-1], exp_w'(exp_max), man_w'(man_max)};
    end else if (mag == '0) begin
      w = '0;
    end else begin
      w = {sum[aw-1], exp_w'(e), mag[man_w-1:0]};
    end
    return w;
  endfunction

  // sum order a0 a1 b0 b1 lands on X0 X2 X1 X3
  function automatic int out_slot(input int j);
    return (j % 2) * 2 + j / 2;
  endfunction

  always_comb begin
    real_words = '0;
    imag_words = '0;
    for (int j = 0; j < n_points; j++) begin
      real_words[out_slot(j)*word_w +: word_w] =
        pack(real_sums[j*aw +: aw], real_exps[(j/2)*exp_w +: exp_w]);
      imag_words[out_slot(j)*word_w +: word_w] =
        pack(imag_sums[j*aw +: aw], imag_exps[(j/2)*exp_w +: exp_w]);
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      start_d <= '0;
      done    <= 1'b0;
      y_real  <= '0;
      y_imag  <= '0;
    end else begin
      start_d <= {start_d[1:0], start};
      done    <= start_d[2];
      if (start_d[2]) begin
        y_real <= real_words;
        y_imag <= imag_words;
      end
    end
  end

  // back-to-back dones need back-to-back starts four edges earlier
  a_done_pairs : assert property (
    @(posedge clk) disable iff (!rst)
      done && $past(done) |-> $past(start, 4) && $past(start, 5)
  );

endmodule

`default_nettype wire

// File: rtl/dft4_bfp_top.sv
// 4-point DFT, free-running pipeline; done three edges after start, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module dft4_bfp_top
  import dft4_pkg::*;
#(
  parameter int low_expand = 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic [n_points*word_w-1:0] x_real,
  input  logic [n_points*word_w-1:0] x_imag,
  output logic [n_points*word_w-1:0] y_real,
  output logic [n_points*word_w-1:0] y_imag,
  output logic                       done
);

  localparam int aw = acc_w(low_expand);

  logic signed [aw-1:0] re_a0, re_a1, re_b0, re_b1;
  logic signed [aw-1:0] im_a0, im_a1, im_b0, im_b1;
  logic [exp_w-1:0]     re_exp_a, re_exp_b;
  logic [exp_w-1:0]     im_exp_a, im_exp_b;

  bfp_lane #(
    .low_expand(low_expand),
    .lane      (lane_real)
  ) u_real_lane (
    .clk      (clk),
    .rst      (rst),
    .x_real   (x_real),
    .x_imag   (x_imag),
    .sum_a0   (re_a0),
    .sum_a1   (re_a1),
    .sum_b0   (re_b0),
    .sum_b1   (re_b1),
    .max_exp_a(re_exp_a),
    .max_exp_b(re_exp_b)
  );

  bfp_lane #(
    .low_expand(low_expand),
    .lane      (lane_imag)
  ) u_imag_lane (
    .clk      (clk),
    .rst      (rst),
    .x_real   (x_real),
    .x_imag   (x_imag),
    .sum_a0   (im_a0),
    .sum_a1   (im_a1),
    .sum_b0   (im_b0),
    .sum_b1   (im_b1),
    .max_exp_a(im_exp_a),
    .max_exp_b(im_exp_b)
  );

  sfp_packer #(
    .low_expand(low_expand)
  ) u_packer (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .real_sums({re_b1, re_b0, re_a1, re_a0}),  // a0 in the low slot
    .imag_sums({im_b1, im_b0, im_a1, im_a0}),
    .real_exps({re_exp_b, re_exp_a}),
    .imag_exps({im_exp_b, im_exp_a}),
    .y_real   (y_real),
    .y_imag   (y_imag),
    .done     (done)
  );

endmodule

`default_nettype wire

// File: dv/dft4_tb.sv
// testbench for dft4_bfp_top at low_expand 2; expects done three edges after each sampled start
`timescale 1ns/1ps
`default_nettype none

module dft4_tb
  import dft4_pkg::*;
;

  localparam int low_expand = 2;

  logic        clk;
  logic        rst;
  logic        start;
  logic [35:0] x_real;
  logic [35:0] x_imag;
  logic [35:0] y_real;
  logic [35:0] y_imag;
  logic        done;

  logic [31:0] lfsr_state = 32'h3ff9c181;
  int          cyc = 0;
  int          mismatch_errs = 0;
  int          other_errs = 0;

  logic [71:0] want_q [$];  // {y_imag, y_real}
  string       name_q [$];
  int          edge_q [$];
  logic [71:0] want;
  string       want_name;
  int          want_edge;
  logic [71:0] held;  // last expected output pair

  dft4_bfp_top #(
    .low_expand(low_expand)
  ) u_dft4_bfp_top (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .x_real(x_real),
    .x_imag(x_imag),
    .y_real(y_real),
    .y_imag(y_imag),
    .done  (done)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // galois form, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [35:0] rand_bus();
    logic [35:0] b;
    for (int k = 0; k < n_points; k++) begin
      b[k*word_w +: word_w] = rand_bits(word_w);
    end
    return b;
  endfunction

  function automatic int align_term(input logic [8:0] w, input int maxe);
    int m;
    int t;
    m = w[3:0];
    t = (m * (1 << low_expand)) >> (maxe - int'(w[7:4]));
    return w[8] ? -t : t;
  endfunction

  function automatic logic [8:0] pack_word(input int sum, input int maxe);
    int mag;
    int e;
    mag = (sum < 0) ? -sum : sum;
    e   = maxe - low_expand;
    while (mag > 15) begin
      mag = mag / 2;
      e   = e + 1;
    end
    if (e < 0) begin
      mag = mag >> (-e);
      e   = 0;
    end
    if (e > 15) return {sum < 0, 4'd15, 4'd15};
    if (mag == 0) return 9'd0;
    return {sum < 0, 4'(e), 4'(mag)};
  endfunction

  // returns {second sum word, first sum word}
  function automatic logic [17:0] ref_group(input logic [35:0] g, input bit odd);
    int maxe;
    int t [4];
    int p0;
    int p1;
    maxe = 0;
    for (int k = 0; k < 4; k++) begin
      if (int'(g[k*9+4 +: 4]) > maxe) maxe = g[k*9+4 +: 4];
    end
    for (int k = 0; k < 4; k++) t[k] = align_term(g[k*9 +: 9], maxe);
    p0 = odd ? t[0] - t[1] : t[0] + t[1];
    p1 = odd ? t[2] - t[3] : t[2] + t[3];
    return {pack_word(p0 - p1, maxe), pack_word(p0 + p1, maxe)};
  endfunction

  function automatic logic [71:0] ref_dft(input logic [35:0] xr, input logic [35:0] xi);
    logic [8:0]  r [4];
    logic [8:0]  i [4];
    logic [17:0] ra, rb, ia, ib;
    for (int k = 0; k < 4; k++) begin
      r[k] = xr[k*9 +: 9];
      i[k] = xi[k*9 +: 9];
    end
    ra = ref_group({r[3], r[1], r[2], r[0]}, 1'b0);
    rb = ref_group({i[3], i[1], r[2], r[0]}, 1'b1);
    ia = ref_group({i[3], i[1], i[2], i[0]}, 1'b0);
    ib = ref_group({r[1], r[3], i[2], i[0]}, 1'b1);
    return {ib[17:9], ia[17:9], ib[8:0], ia[8:0], rb[17:9], ra[17:9], rb[8:0], ra[8:0]};
  endfunction

  task automatic issue(input string name, input logic [35:0] xr, input logic [35:0] xi,
                       input logic [71:0] expect_y);
    @(negedge clk);
    start  = 1'b1;
    x_real = xr;
    x_imag = xi;
    want_q.push_back(expect_y);
    name_q.push_back(name);
    edge_q.push_back(cyc + 1);
  endtask

  task automatic release_start();
    @(negedge clk);
    start  = 1'b0;
    x_real = ~x_real;  // junk on the bus while idle
    x_imag = ~x_imag;
  endtask

  task automatic drain_pipeline(input string name);
    for (int t = 0; t < 20 && want_q.size() > 0; t++) @(negedge clk);
    if (want_q.size() > 0) begin
      other_errs++;
      $display("timeout: %s still has %0d transforms without done", name, want_q.size());
      want_q.delete();
      name_q.delete();
      edge_q.delete();
    end
  endtask

  // scoreboard
  always @(negedge clk) begin
    if (rst && done) begin
      if (want_q.size() == 0) begin
        other_errs++;
        $display("done went high with no transform pending at edge %0d", cyc);
      end else begin
        want      = want_q.pop_front();
        want_name = name_q.pop_front();
        want_edge = edge_q.pop_front();
        held      = want;
        if (cyc != want_edge + 3) begin
          other_errs++;
          $display("%s: done came on edge %0d, expected edge %0d", want_name, cyc,
                   want_edge + 3);
        end
        for (int k = 0; k < n_points; k++) begin
          if (y_real[k*9 +: 9] !== want[k*9 +: 9]) begin
            mismatch_errs++;
            $display("MISMATCH %s y_real[%0d] expected %03h actual %03h", want_name, k,
                     want[k*9 +: 9], y_real[k*9 +: 9]);
          end
          if (y_imag[k*9 +: 9] !== want[36+k*9 +: 9]) begin
            mismatch_errs++;
            $display("MISMATCH %s y_imag[%0d] expected %03h actual %03h", want_name, k,
                     want[36+k*9 +: 9], y_imag[k*9 +: 9]);
          end
        end
      end
    end else if (rst && {y_imag, y_real} !== held) begin
      // outputs keep their value between dones
      mismatch_errs++;
      $display("MISMATCH hold expected %h actual %h", held, {y_imag, y_real});
    end
  end

  initial begin
    logic [35:0] xr;
    logic [35:0] xi;
    rst    = 1'b0;
    start  = 1'b0;
    x_real = '0;
    x_imag = '0;
    held   = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;

    // idle outputs after reset
    repeat (5) begin
      @(negedge clk);
      if (done !== 1'b0 || y_real !== '0 || y_imag !== '0) begin
        mismatch_errs++;
        $display("MISMATCH idle expected %h actual %h", 73'd0, {done, y_imag, y_real});
      end
    end

    issue("impulse_pos", {27'd0, 9'h06b}, '0, {36'd0, {4{9'h06b}}});
    release_start();
    drain_pipeline("impulse_pos");
    issue("impulse_neg", {27'd0, 9'h16b}, '0, {36'd0, {4{9'h16b}}});
    release_start();
    drain_pipeline("impulse_neg");

    for (int n = 0; n < 20; n++) begin
      xr = rand_bus();
      xi = rand_bus();
      issue("random_single", xr, xi, ref_dft(xr, xi));
      release_start();
      drain_pipeline("random_single");
    end

    for (int n = 0; n < 12; n++) begin
      xr = rand_bus();
      xi = rand_bus();
      issue("back_to_back", xr, xi, ref_dft(xr, xi));
    end
    release_start();
    drain_pipeline("back_to_back");

    // small neighbors shift out completely
    xr = {9'h02f, 9'h02f, 9'h02f, 9'h0cf};
    issue("exp_spread", xr, '0, ref_dft(xr, '0));
    xi = {9'h12f, 9'h0af, 9'h03f, 9'h0c7};
    issue("exp_spread_imag", '0, xi, ref_dft('0, xi));
    release_start();
    drain_pipeline("exp_spread");

    issue("saturation", {4{9'h0ff}}, '0, {36'd0, 27'd0, 9'h0ff});
    release_start();
    drain_pipeline("saturation");

    repeat (3) @(negedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
rtl/dft4_pkg.sv
rtl/group_aligner.sv
rtl/bfp_lane.sv
rtl/sfp_packer.sv
rtl/dft4_bfp_top.sv
dv/dft4_tb.sv
